/* design/dzcpu_config.svh */
`ifndef DZCPU_CONFIG_SVH
`define DZCPU_CONFIG_SVH

////////////////////
// Bus widths
////////////////////

// Memory port
`define DZ_ADDR_W 16
`define DZ_DATA_W 8

// Micro program counter and flow index
`define DZ_UIDX_W 8

// Register values after reset
`define DZ_PC_RESET 16'h0000
`define DZ_SP_RESET 16'hFFFE

////////////////////
// Opcodes of the subset
////////////////////

// 16-bit immediate loads
`define OP_LDSPNN 8'h31
`define OP_LDHLNN 8'h21
`define OP_LDDENN 8'h11

// 8-bit immediate loads
`define OP_LDAN 8'h3E
`define OP_LDBN 8'h06
`define OP_LDCN 8'h0E

// Stores through HL, load through DE
`define OP_LDHLA 8'h77
`define OP_LDHLIA 8'h22
`define OP_LDHLDA 8'h32
`define OP_LDADE 8'h1A

// Increment, decrement, stack
`define OP_INCC 8'h0C
`define OP_DECB 8'h05
`define OP_INCHL 8'h23
`define OP_PUSHBC 8'hC5
`define OP_POPBC 8'hC1

`endif

/* design/dzcpuPkg.sv */
package dzcpuPkg;

	////////////////////
	// Micro-op fields
	////////////////////

	// Sequencing field, what happens after the micro-op
	typedef enum logic [1:0]
	{
		op     = 2'd0,
		inc    = 2'd1,
		eof    = 2'd2,
		incEof = 2'd3
	} uopFlow;

	// Action field
	typedef enum logic [4:0]
	{
		nop   = 5'd0,
		sma   = 5'd1,
		srm   = 5'd2,
		smw   = 5'd3,
		inc16 = 5'd4,
		dec16 = 5'd5,
		ldA   = 5'd6  // reserved, no flow uses it yet
	} uopAction;

	// Operand field
	typedef enum logic [4:0]
	{
		// Byte registers
		a    = 5'd0,
		b    = 5'd1,
		c    = 5'd2,
		d    = 5'd3,
		e    = 5'd4,
		h    = 5'd5,
		l    = 5'd6,
		spl  = 5'd7,
		sph  = 5'd8,
		// Register pairs
		pc   = 5'd9,
		hl   = 5'd10,
		de   = 5'd11,
		sp   = 5'd12,
		bc   = 5'd13,
		none = 5'd31
	} uopOperand;

	// One ROM word, 12 bits
	typedef struct packed
	{
		uopFlow    flow;
		uopAction  action;
		uopOperand operand;
	} uopWord;

endpackage

/* design/ucodeLut.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module ucodeLut
(
	input  logic [`DZ_DATA_W-1:0] opcode,
	output logic [`DZ_UIDX_W-1:0] flowIdx
);

	////////////////////
	// Opcode to flow start
	////////////////////

	always_comb
	begin
		case (opcode)
			// Immediate 16-bit loads
			`OP_LDSPNN: flowIdx = 8'd1;
			`OP_LDHLNN: flowIdx = 8'd4;
			`OP_LDDENN: flowIdx = 8'd7;
			// Immediate 8-bit loads
			`OP_LDAN:   flowIdx = 8'd10;
			`OP_LDBN:   flowIdx = 8'd12;
			`OP_LDCN:   flowIdx = 8'd14;
			// Memory through HL
			`OP_LDHLA:  flowIdx = 8'd16;
			`OP_LDHLIA: flowIdx = 8'd19;
			`OP_LDHLDA: flowIdx = 8'd23;
			// Memory through DE
			`OP_LDADE:  flowIdx = 8'd27;
			// Single-step arithmetic
			`OP_INCC:   flowIdx = 8'd30;
			`OP_DECB:   flowIdx = 8'd31;
			`OP_INCHL:  flowIdx = 8'd32;
			// Stack
			`OP_PUSHBC: flowIdx = 8'd33;
			`OP_POPBC:  flowIdx = 8'd39;
			// Anything else is a one-byte no-op
			default:    flowIdx = 8'd0;
		endcase
	end

endmodule

/* design/ucodeRom.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module ucodeRom import dzcpuPkg::*;
(
	input  logic [`DZ_UIDX_W-1:0] uIdx,
	output uopWord                uop
);

	////////////////////
	// Flow table
	////////////////////

	// Read is combinational, so srm takes the byte at the
	// address that is selected in the same cycle
	always_comb
	begin
		case (uIdx)
			// Unknown opcode, skip one byte
			8'd0:  uop = '{incEof, nop, none};
			// LD SP,nn
			8'd1:  uop = '{inc, sma, pc};
			8'd2:  uop = '{inc, srm, spl};
			8'd3:  uop = '{incEof, srm, sph};
			// LD HL,nn
			8'd4:  uop = '{inc, sma, pc};
			8'd5:  uop = '{inc, srm, l};
			8'd6:  uop = '{incEof, srm, h};
			// LD DE,nn
			8'd7:  uop = '{inc, sma, pc};
			8'd8:  uop = '{inc, srm, e};
			8'd9:  uop = '{incEof, srm, d};
			// LD A,n
			8'd10: uop = '{inc, sma, pc};
			8'd11: uop = '{incEof, srm, a};
			// LD B,n
			8'd12: uop = '{inc, sma, pc};
			8'd13: uop = '{incEof, srm, b};
			// LD C,n
			8'd14: uop = '{inc, sma, pc};
			8'd15: uop = '{incEof, srm, c};
			// LD (HL),A
			8'd16: uop = '{inc, sma, hl};
			8'd17: uop = '{op, smw, a};
			8'd18: uop = '{eof, sma, pc};
			// LD (HL+),A, store first then step HL
			8'd19: uop = '{inc, sma, hl};
			8'd20: uop = '{op, smw, a};
			8'd21: uop = '{op, inc16, hl};
			8'd22: uop = '{eof, sma, pc};
			// LD (HL-),A
			8'd23: uop = '{inc, sma, hl};
			8'd24: uop = '{op, smw, a};
			8'd25: uop = '{op, dec16, hl};
			8'd26: uop = '{eof, sma, pc};
			// LD A,(DE)
			8'd27: uop = '{inc, sma, de};
			8'd28: uop = '{op, srm, a};
			8'd29: uop = '{eof, sma, pc};
			// INC C
			8'd30: uop = '{incEof, inc16, c};
			// DEC B
			8'd31: uop = '{incEof, dec16, b};
			// INC HL
			8'd32: uop = '{incEof, inc16, hl};
			// PUSH BC, B lands at SP-1 and C at SP-2
			8'd33: uop = '{inc, dec16, sp};
			8'd34: uop = '{op, sma, sp};
			8'd35: uop = '{op, smw, b};
			8'd36: uop = '{op, dec16, sp};
			8'd37: uop = '{op, smw, c};
			8'd38: uop = '{eof, sma, pc};
			// POP BC, C from SP and B from SP+1
			8'd39: uop = '{inc, sma, sp};
			8'd40: uop = '{op, srm, c};
			8'd41: uop = '{op, inc16, sp};
			8'd42: uop = '{op, srm, b};
			8'd43: uop = '{op, inc16, sp};
			8'd44: uop = '{eof, sma, pc};
			// Unused slots
			default: uop = '{op, nop, none};
		endcase
	end

endmodule

/* design/uopSequencer.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module uopSequencer import dzcpuPkg::*;
(
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [`DZ_UIDX_W-1:0] flowIdx,
	input  uopWord                uop,
	output logic [`DZ_UIDX_W-1:0] uIdx,
	output logic                  fetch,
	output logic                  uopValid
);

	////////////////////
	// State
	////////////////////

	typedef enum logic
	{
		stFetch = 1'b0,
		stExec  = 1'b1
	} seqState;

	seqState state;
	logic    flowEnds;

	// Last micro-op of a flow
	assign flowEnds = (uop.flow == eof) || (uop.flow == incEof);

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= stFetch;
			uIdx  <= '0;
		end
		else
		begin
			case (state)
				// Opcode on the bus, jump to its flow
				stFetch:
				begin
					uIdx  <= flowIdx;
					state <= stExec;
				end
				// One micro-op per cycle
				stExec:
				begin
					if (flowEnds)
					begin
						state <= stFetch;
					end
					else
					begin
						uIdx <= uIdx + 1'b1;
					end
				end
				default:
				begin
					state <= stFetch;
				end
			endcase
		end
	end

	// Status to the datapath
	assign fetch    = (state == stFetch);
	assign uopValid = (state == stExec);

endmodule

/* design/cpuDatapath.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module cpuDatapath import dzcpuPkg::*;
(
	input  logic                  clock,
	input  logic                  rstN,
	input  uopWord                uop,
	input  logic                  uopValid,
	input  logic                  fetch,
	input  logic [`DZ_DATA_W-1:0] memRdData,
	output logic [`DZ_ADDR_W-1:0] memAddr,
	output logic [`DZ_DATA_W-1:0] memWrData,
	output logic                  memWe
);

	// Architectural registers
	logic [`DZ_DATA_W-1:0] regA, regB, regC, regD, regE, regH, regL;
	logic [`DZ_ADDR_W-1:0] regSp, regPc;
	// Current memory address source
	uopOperand             addrSel;

	// Operand views and results
	logic [`DZ_DATA_W-1:0] regVal8, byteData;
	logic [`DZ_ADDR_W-1:0] pairVal, pairStep, selAddr;
	logic                  isByte, stepUp, isStep, byteWr, pairWr, pcInc;

	////////////////////
	// Operand decode
	////////////////////

	always_comb
	begin
		regVal8 = '0;
		isByte  = 1'b1;
		case (uop.operand)
			a:   regVal8 = regA;
			b:   regVal8 = regB;
			c:   regVal8 = regC;
			d:   regVal8 = regD;
			e:   regVal8 = regE;
			h:   regVal8 = regH;
			l:   regVal8 = regL;
			spl: regVal8 = regSp[7:0];
			sph: regVal8 = regSp[15:8];
			default: isByte = 1'b0;
		endcase
		// Pair view of the same field
		case (uop.operand)
			hl:      pairVal = {regH, regL};
			de:      pairVal = {regD, regE};
			sp:      pairVal = regSp;
			bc:      pairVal = {regB, regC};
			default: pairVal = '0;
		endcase
	end

	// Step direction and wrapped results
	assign stepUp   = (uop.action == inc16);
	assign isStep   = (uop.action == inc16) || (uop.action == dec16);
	assign pairStep = stepUp ? pairVal + 16'd1 : pairVal - 16'd1;
	assign byteData = (uop.action == srm) ? memRdData
		: (stepUp ? regVal8 + 8'd1 : regVal8 - 8'd1);

	// Write enables
	assign byteWr = uopValid && isByte && ((uop.action == srm) || isStep);
	assign pairWr = uopValid && !isByte && isStep;
	assign pcInc  = uopValid && ((uop.flow == inc) || (uop.flow == incEof));

	////////////////////
	// Memory port
	////////////////////

	// Live view of the selected register
	always_comb
	begin
		case (addrSel)
			hl:      selAddr = {regH, regL};
			de:      selAddr = {regD, regE};
			sp:      selAddr = regSp;
			bc:      selAddr = {regB, regC};
			default: selAddr = regPc;
		endcase
	end

	// Fetch always reads at PC
	assign memAddr   = fetch ? regPc : selAddr;
	assign memWrData = regVal8;
	assign memWe     = uopValid && (uop.action == smw);

	////////////////////
	// Register update
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			regA    <= '0;
			regB    <= '0;
			regC    <= '0;
			regD    <= '0;
			regE    <= '0;
			regH    <= '0;
			regL    <= '0;
			regSp   <= `DZ_SP_RESET;
			regPc   <= `DZ_PC_RESET;
			addrSel <= pc;
		end
		else
		begin
			// Address select
			if (fetch)
				addrSel <= pc;
			else if (uopValid && (uop.action == sma))
				addrSel <= uop.operand;
			// Covers the opcode and operand bytes
			if (pcInc)
				regPc <= regPc + 16'd1;
			if (byteWr)
			begin
				case (uop.operand)
					a:   regA <= byteData;
					b:   regB <= byteData;
					c:   regC <= byteData;
					d:   regD <= byteData;
					e:   regE <= byteData;
					h:   regH <= byteData;
					l:   regL <= byteData;
					spl: regSp[7:0] <= byteData;
					sph: regSp[15:8] <= byteData;
					default: ;
				endcase
			end
			if (pairWr)
			begin
				case (uop.operand)
					hl: {regH, regL} <= pairStep;
					de: {regD, regE} <= pairStep;
					sp: regSp <= pairStep;
					bc: {regB, regC} <= pairStep;
					default: ;
				endcase
			end
		end
	end

endmodule

/* design/dzcpuCore.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module dzcpuCore import dzcpuPkg::*;
(
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [`DZ_DATA_W-1:0] memRdData,
	output logic [`DZ_ADDR_W-1:0] memAddr,
	output logic [`DZ_DATA_W-1:0] memWrData,
	output logic                  memWe,
	output logic                  opFetch
);

	// Sequencer to tables
	logic [`DZ_UIDX_W-1:0] uIdx, flowIdx;
	uopWord                uop;
	logic                  uopValid;

	////////////////////
	// Control
	////////////////////

	uopSequencer sequencer (
		.clock(clock), .rstN(rstN), .flowIdx(flowIdx), .uop(uop),
		.uIdx(uIdx), .fetch(opFetch), .uopValid(uopValid)
	);

	// Opcode straight off the read bus
	ucodeLut lut (.opcode(memRdData), .flowIdx(flowIdx));

	ucodeRom rom (.uIdx(uIdx), .uop(uop));

	////////////////////
	// Datapath
	////////////////////

	cpuDatapath datapath (
		.clock(clock), .rstN(rstN), .uop(uop), .uopValid(uopValid),
		.fetch(opFetch), .memRdData(memRdData), .memAddr(memAddr),
		.memWrData(memWrData), .memWe(memWe)
	);

endmodule

/* test/dzcpuCore_assert.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module dzcpuCore_assert
(
	input logic                  clock,
	input logic                  rstN,
	input logic                  memWe,
	input logic                  opFetch,
	input logic [`DZ_ADDR_W-1:0] memAddr
);

	////////////////////
	// Port rules
	////////////////////

	// Opcode reads never carry a store
	weNotInFetch: assert property (@(posedge clock) !(memWe && opFetch))
		else $error("memWe and opFetch high in the same cycle");

	// Quiet bus while held in reset
	weLowInReset: assert property (@(posedge clock) !rstN |-> !memWe)
		else $error("memWe high during reset");

	// Store address fully driven
	addrKnownOnWe: assert property (@(posedge clock) memWe |-> !$isunknown(memAddr))
		else $error("memAddr has unknown bits during a write");

endmodule

// Attach to every core instance
bind dzcpuCore dzcpuCore_assert checks
(
	.clock(clock),
	.rstN(rstN),
	.memWe(memWe),
	.opFetch(opFetch),
	.memAddr(memAddr)
);

/* test/dzcpuTb.sv */
`timescale 1ns/1ps
`include "dzcpu_config.svh"

module dzcpuTb;

	localparam int clkPeriod   = 20;
	localparam int resetCycles = 8;
	localparam int numInstr    = 60;
	// Worst flow is PUSH BC with fetch plus six micro-ops
	localparam int timeoutNs   = (resetCycles + (numInstr + 3) * 8) * clkPeriod + 2000;

	logic                  clock, rstN, memWe, opFetch, done, firstFetch;
	logic [`DZ_ADDR_W-1:0] memAddr, genPc, endPc;
	logic [`DZ_DATA_W-1:0] memRdData, memWrData;
	logic [7:0]            mem [0:65535];
	logic [7:0]            modelMem [0:65535];
	// ISA model state
	logic [7:0]            mA, mB, mC, mD, mE, mH, mL;
	logic [15:0]           mSp, mPc;
	// Expected bus activity
	logic [15:0]           fetchQ [$];
	logic [15:0]           wrAddrQ [$];
	logic [7:0]            wrDataQ [$];

	dzcpuCore uut (.clock(clock), .rstN(rstN), .memRdData(memRdData), .memAddr(memAddr),
		.memWrData(memWrData), .memWe(memWe), .opFetch(opFetch));

	// Read data straight from the array
	assign memRdData = mem[memAddr];

	// Memory takes the store on the rising edge
	always @(posedge clock)
	begin
		if (memWe)
			mem[memAddr] <= memWrData;
	end

	initial
	begin
		clock = 1'b0;
		forever #(clkPeriod / 2) clock = ~clock;
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
			reportFailure($sformatf("error at %0d ns: %s got %h expected %h",
				$time, what, actual, expected));
	endtask

	////////////////////
	// Program builder
	////////////////////

	task automatic emitByte(input logic [7:0] value);
		mem[genPc] = value;
		genPc = genPc + 16'd1;
	endtask

	// Little-endian operand
	task automatic emitWord(input logic [15:0] value);
		emitByte(value[7:0]);
		emitByte(value[15:8]);
	endtask

	function automatic logic isSubset(input logic [7:0] opcode);
		case (opcode)
			`OP_LDSPNN, `OP_LDHLNN, `OP_LDDENN, `OP_LDAN, `OP_LDBN, `OP_LDCN,
			`OP_LDHLA, `OP_LDHLIA, `OP_LDHLDA, `OP_LDADE, `OP_INCC, `OP_DECB,
			`OP_INCHL, `OP_PUSHBC, `OP_POPBC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Data region above code
	function automatic logic [15:0] randomAddr();
		int unsigned r;
		r = $urandom_range(32'h8000, 32'hFFF0);
		return r[15:0];
	endfunction

	function automatic logic [7:0] randomByte();
		int unsigned r;
		r = $urandom;
		return r[7:0];
	endfunction

	task automatic buildProgram();
		int unsigned pick;
		logic [7:0]  opcode;
		logic [7:0]  subsetOps [0:14];
		subsetOps = '{`OP_LDSPNN, `OP_LDHLNN, `OP_LDDENN, `OP_LDAN, `OP_LDBN,
			`OP_LDCN, `OP_LDHLA, `OP_LDHLIA, `OP_LDHLDA, `OP_LDADE, `OP_INCC,
			`OP_DECB, `OP_INCHL, `OP_PUSHBC, `OP_POPBC};
		// Pattern over the full address so stray reads differ
		for (int i = 0; i < 65536; i++)
			mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'hA5;
		genPc = 16'h0000;
		for (int n = 0; n < numInstr; n++)
		begin
			pick = $urandom_range(0, 15);
			if (pick < 15)
				opcode = subsetOps[pick];
			else
			begin
				// Opcode outside the subset
				opcode = randomByte();
				while (isSubset(opcode))
					opcode = randomByte();
			end
			emitByte(opcode);
			// Operand bytes
			case (opcode)
				`OP_LDSPNN, `OP_LDHLNN, `OP_LDDENN: emitWord(randomAddr());
				`OP_LDAN, `OP_LDBN, `OP_LDCN: emitByte(randomByte());
				default: ;
			endcase
		end
		// Trailer exposes A, B and C
		emitByte(`OP_LDHLNN);
		emitWord(randomAddr());
		emitByte(`OP_LDHLA);
		emitByte(`OP_PUSHBC);
		endPc = genPc;
	endtask

	////////////////////
	// ISA model
	////////////////////

	task automatic modelWrite(input logic [15:0] addr, input logic [7:0] data);
		wrAddrQ.push_back(addr);
		wrDataQ.push_back(data);
		modelMem[addr] = data;
	endtask

	task automatic runModel();
		logic [7:0]  opcode;
		logic [15:0] hlv;
		for (int i = 0; i < 65536; i++)
			modelMem[i[15:0]] = mem[i[15:0]];
		{mA, mB, mC, mD, mE, mH, mL} = '0;
		mSp = `DZ_SP_RESET;
		mPc = 16'h0000;
		while (mPc < endPc)
		begin
			fetchQ.push_back(mPc);
			opcode = modelMem[mPc];
			hlv = {mH, mL};
			case (opcode)
				`OP_LDSPNN: mSp = {modelMem[mPc + 16'd2], modelMem[mPc + 16'd1]};
				`OP_LDHLNN: {mH, mL} = {modelMem[mPc + 16'd2], modelMem[mPc + 16'd1]};
				`OP_LDDENN: {mD, mE} = {modelMem[mPc + 16'd2], modelMem[mPc + 16'd1]};
				`OP_LDAN:   mA = modelMem[mPc + 16'd1];
				`OP_LDBN:   mB = modelMem[mPc + 16'd1];
				`OP_LDCN:   mC = modelMem[mPc + 16'd1];
				`OP_LDHLA:  modelWrite(hlv, mA);
				`OP_LDHLIA:
				begin
					modelWrite(hlv, mA);
					{mH, mL} = hlv + 16'd1;
				end
				`OP_LDHLDA:
				begin
					modelWrite(hlv, mA);
					{mH, mL} = hlv - 16'd1;
				end
				`OP_LDADE:  mA = modelMem[{mD, mE}];
				`OP_INCC:   mC = mC + 8'd1;
				`OP_DECB:   mB = mB - 8'd1;
				`OP_INCHL:  {mH, mL} = hlv + 16'd1;
				`OP_PUSHBC:
				begin
					mSp = mSp - 16'd1;
					modelWrite(mSp, mB);
					mSp = mSp - 16'd1;
					modelWrite(mSp, mC);
				end
				`OP_POPBC:
				begin
					mC = modelMem[mSp];
					mB = modelMem[mSp + 16'd1];
					mSp = mSp + 16'd2;
				end
				default: ;
			endcase
			// Opcode plus operand bytes
			case (opcode)
				`OP_LDSPNN, `OP_LDHLNN, `OP_LDDENN: mPc = mPc + 16'd3;
				`OP_LDAN, `OP_LDBN, `OP_LDCN: mPc = mPc + 16'd2;
				default: mPc = mPc + 16'd1;
			endcase
		end
	endtask

	////////////////////
	// Bus checks
	////////////////////

	task automatic checkWrite();
		if (wrAddrQ.size() == 0)
			reportFailure("The core wrote to memory when the model expected no write");
		else
		begin
			compareValue(memAddr, wrAddrQ.pop_front(), "write address");
			compareValue({8'h00, memWrData}, {8'h00, wrDataQ.pop_front()}, "write data");
		end
	endtask

	task automatic checkFetch();
		if (firstFetch)
			compareValue(memAddr, 16'h0000, "first fetch address");
		firstFetch = 1'b0;
		if (fetchQ.size() == 0)
		begin
			// Program finished with no write left pending
			compareValue(memAddr, endPc, "final fetch address");
			compareValue(16'(wrAddrQ.size()), 16'h0000, "pending writes");
			done = 1'b1;
		end
		else
			compareValue(memAddr, fetchQ.pop_front(), "fetch address");
	endtask

	initial
	begin
		#(timeoutNs);
		reportFailure("Watchdog expired before the core ran past the end of the program");
	end

	initial
	begin
		rstN       = 1'b0;
		done       = 1'b0;
		firstFetch = 1'b1;
		void'($urandom(32'h6c65_3d70));
		buildProgram();
		runModel();
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1;
		// Sample mid-cycle where outputs are settled
		while (!done)
		begin
			@(negedge clock);
			if (memWe)
				checkWrite();
			if (opFetch)
				checkFetch();
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

/* dzcpu.f */
+incdir+design
design/dzcpuPkg.sv
design/ucodeLut.sv
design/ucodeRom.sv
design/uopSequencer.sv
design/cpuDatapath.sv
design/dzcpuCore.sv
test/dzcpuCore_assert.sv
test/dzcpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dzcpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dzcpu.f --top-module dzcpuTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/VdzcpuTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" <<< "$output"; then
	exit 0
else
	echo "Pass line missing from simulation output"
	exit 1
fi
